//--- include/inv_params.svh
// ----------------------------------------------------------
// field positions of the trimmed return packet and sizes of
// the icache valid array, included by package and RTL
// ----------------------------------------------------------
`ifndef INV_PARAMS_SVH
`define INV_PARAMS_SVH

// trimmed return packet
`define INV_PKT_WIDTH   81

// invalidation vector, two 32-bit words
`define INV_W0_LO       0
`define INV_W1_LO       32
// one cpu-pair group is 8 bits wide
`define INV_GRP_W       8
// odd core sits 4 bits above the even core
`define INV_ODD_OFS     4
// valid bit and way offset inside one core's nibble
`define INV_VLD_OFS     1
`define INV_WAY_OFS     2

// invalidate index, address bits 11:6
`define INV_IDX_LO      64
`define INV_IDX_HI      69
// load invalidate way and flags
`define INV_WAY_LO      70
`define INV_WAY_HI      71
`define INV_WYVLD       72
`define INV_PA5         73
`define INV_IINV        74
// thread id of the packet
`define INV_THR_LO      75
`define INV_THR_HI      76
// valid bit plus type, bit 80 is the valid
`define INV_OP_LO       77
`define INV_OP_HI       80

// icache geometry
// index bit 0 is address bit 5
`define IC_IDX_W        7
`define IC_WAYS         4
`define IFU_THREADS     4

`endif

//--- logic/inv_pkg.sv
// ----------------------------------------------------------
// shared types of the invalidation control, referenced by
// scoped name from decode, write control and top level
// ----------------------------------------------------------
`include "inv_params.svh"

package inv_pkg;

   // ---------------------------------------------------------
   // return packet opcodes
   // ---------------------------------------------------------
   // msb is the packet valid, low three bits the type
   typedef enum logic [3:0] {
      op_idle      = 4'b0000,
      op_load      = 4'b1000,
      op_ifill     = 4'b1001,
      op_evict     = 4'b1011,
      op_store_ack = 4'b1100,
      op_strm_ack  = 4'b1110
   } cpx_op_e;

   // ---------------------------------------------------------
   // valid array addressing
   // ---------------------------------------------------------
   // line index, address bits 11:5
   typedef logic [`IC_IDX_W-1:0] ic_index_t;

   // way number
   typedef logic [$clog2(`IC_WAYS)-1:0] ic_way_t;

   // four groups of four ways
   // order w0 low, w1 low, w0 high, w1 high
   typedef logic [4*`IC_WAYS-1:0] icv_wren_t;

endpackage

//--- logic/inv_pkt_decode.sv
// ----------------------------------------------------------
// decodes the fill queue return packet and pulls out this
// core's invalidation bits and ways; purely combinational
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "inv_params.svh"

module inv_pkt_decode (
   input  logic [2:0]                const_cpuid,
   input  logic [`INV_PKT_WIDTH-1:0] ifqop,
   output inv_pkg::cpx_op_e          op,
   output logic                      ld_inv,
   output inv_pkg::ic_way_t          ld_way,
   output logic                      word0_inv,
   output logic                      word1_inv,
   output inv_pkg::ic_way_t          wd0_way,
   output inv_pkg::ic_way_t          wd1_way,
   output logic [5:0]                inv_index,
   output logic                      iinv,
   output logic                      pa5,
   output logic [1:0]                pkt_thr
);

   // raw opcode field
   logic [3:0] op_raw;
   // bit offset of this core inside one invalidation word
   logic [4:0] ofs;

   // ---------------------------------------------------------
   // packet type
   // ---------------------------------------------------------
   assign op_raw = ifqop[`INV_OP_HI:`INV_OP_LO];

   // no valid bit means no packet
   assign op = op_raw[3] ? inv_pkg::cpx_op_e'(op_raw) : inv_pkg::op_idle;

   // load carries an invalidation only with way-valid set
   assign ld_inv = (op == inv_pkg::op_load) & ifqop[`INV_WYVLD];
   assign ld_way = ifqop[`INV_WAY_HI:`INV_WAY_LO];

   // ---------------------------------------------------------
   // this core's slice of the invalidation vector
   // ---------------------------------------------------------
   // cpuid 2:1 picks the pair, 8 bits per pair
   // cpuid 0 picks even or odd, 4 bits apart
   assign ofs = {const_cpuid[2:1], const_cpuid[0], 2'b00};

   // word 0
   assign word0_inv = ifqop[`INV_W0_LO + `INV_VLD_OFS + ofs];
   assign wd0_way   = ifqop[`INV_W0_LO + `INV_WAY_OFS + ofs +: 2];

   // word 1, same layout 32 bits up
   assign word1_inv = ifqop[`INV_W1_LO + `INV_VLD_OFS + ofs];
   assign wd1_way   = ifqop[`INV_W1_LO + `INV_WAY_OFS + ofs +: 2];

   // ---------------------------------------------------------
   // remaining fields
   // ---------------------------------------------------------
   // line index, address 11:6
   assign inv_index = ifqop[`INV_IDX_HI:`INV_IDX_LO];

   // invalidate-all and its word select
   assign iinv = ifqop[`INV_IINV];
   assign pa5  = ifqop[`INV_PA5];

   // thread for the load index lookup
   assign pkt_thr = ifqop[`INV_THR_HI:`INV_THR_LO];

   // ---------------------------------------------------------
   // checks
   // ---------------------------------------------------------
   // the fill queue only sends known packet types when valid
   a_op_legal: assert final ($isunknown(op_raw) ||
                             op inside {inv_pkg::op_idle,
                                        inv_pkg::op_load,
                                        inv_pkg::op_ifill,
                                        inv_pkg::op_evict,
                                        inv_pkg::op_store_ack,
                                        inv_pkg::op_strm_ack})
      else $error("unknown return packet opcode %h", op_raw);

endmodule

//--- logic/ld_index_table.sv
// ----------------------------------------------------------
// per-thread table of icache indexes of outstanding loads;
// written on the load strobe, read by the packet thread
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "inv_params.svh"

module ld_index_table (
   input  logic                rclk,
   input  logic                rst_n,
   input  logic                ld_pkt_vld,
   input  logic [1:0]          ld_tid,
   input  inv_pkg::ic_index_t  ld_index,
   input  logic [1:0]          pkt_thr,
   output inv_pkg::ic_index_t  ld_inv_index
);

   // one index per thread
   inv_pkg::ic_index_t idx_q [`IFU_THREADS];

   // ---------------------------------------------------------
   // table write
   // ---------------------------------------------------------
   // new index visible the cycle after the strobe
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         for (int t = 0; t < `IFU_THREADS; t++) begin
            idx_q[t] <= '0;
         end
      end else if (ld_pkt_vld) begin
         idx_q[ld_tid] <= ld_index;
      end
   end

   // ---------------------------------------------------------
   // table read
   // ---------------------------------------------------------
   // thread comes from the return packet
   assign ld_inv_index = idx_q[pkt_thr];

   // ---------------------------------------------------------
   // checks
   // ---------------------------------------------------------
   // lsu must give a clean thread id with the strobe
   a_tid_known: assert property (
      @(posedge rclk) disable iff (!rst_n)
      ld_pkt_vld |-> !$isunknown(ld_tid))
      else $error("load strobe with unknown thread id");

endmodule

//--- logic/icv_write_ctl.sv
// ----------------------------------------------------------
// builds the valid array write index, enables and the
// invalidation request; holds ways, enables and request
// while the fill queue is stalled
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "inv_params.svh"

module icv_write_ctl (
   input  logic               rclk,
   input  logic               rst_n,
   input  logic               ifqadv,
   input  logic               asireq,
   input  inv_pkg::ic_way_t   wrway,
   input  inv_pkg::ic_index_t fill_index,
   input  inv_pkg::cpx_op_e   op,
   input  logic               ld_inv,
   input  inv_pkg::ic_way_t   ld_way,
   input  logic               word0_inv,
   input  logic               word1_inv,
   input  inv_pkg::ic_way_t   wd0_way,
   input  inv_pkg::ic_way_t   wd1_way,
   input  logic [5:0]         inv_index,
   input  logic               iinv,
   input  logic               pa5,
   input  inv_pkg::ic_index_t ld_inv_index,
   output inv_pkg::ic_index_t icv_wrindex,
   output inv_pkg::icv_wren_t icv_wren,
   output logic               invreq,
   output logic               inv_pending
);

   logic                  wrreq;
   logic                  inv_pkt;
   logic                  pick_wr;
   logic                  invall;
   logic                  invalidate;
   inv_pkg::ic_way_t      w0_way;
   inv_pkg::ic_way_t      w1_way;
   inv_pkg::ic_way_t      w0_way_q;
   inv_pkg::ic_way_t      w1_way_q;
   logic [`IC_WAYS-1:0]   w0_dec;
   logic [`IC_WAYS-1:0]   w1_dec;
   // word enables, same order as the wren groups
   logic [3:0]            wrt_en;
   logic [3:0]            wrt_en_bf;
   logic [3:0]            wrt_en_q;
   logic                  inv_q;

   // ---------------------------------------------------------
   // request type
   // ---------------------------------------------------------
   // fill or asi write
   assign wrreq = (op == inv_pkg::op_ifill) | asireq;

   // packets carrying an invalidation vector
   assign inv_pkt = (op == inv_pkg::op_store_ack) |
                    (op == inv_pkg::op_strm_ack) |
                    (op == inv_pkg::op_evict);

   // clear all ways, only on an accepted store ack
   assign invall = (op == inv_pkg::op_store_ack) & iinv & ifqadv;

   // ---------------------------------------------------------
   // way selection
   // ---------------------------------------------------------
   assign pick_wr = wrreq & ifqadv;

   // stall repeats the held ways
   assign w0_way = pick_wr ? wrway :
                   !ifqadv ? w0_way_q :
                   ld_inv  ? ld_way : wd0_way;
   assign w1_way = pick_wr ? wrway :
                   !ifqadv ? w1_way_q :
                   ld_inv  ? ld_way : wd1_way;

   // one-hot way
   assign w0_dec = `IC_WAYS'(1) << w0_way;
   assign w1_dec = `IC_WAYS'(1) << w1_way;

   // ---------------------------------------------------------
   // word enables
   // ---------------------------------------------------------
   // invalidates pick the half by address 6
   // loads and fills pick one quarter by address 6:5
   assign wrt_en[0] = word0_inv & inv_pkt & ~inv_index[0] |
                      ld_inv & (ld_inv_index[1:0] == 2'd0) |
                      wrreq & (fill_index[1:0] == 2'd0);
   assign wrt_en[1] = word1_inv & inv_pkt & ~inv_index[0] |
                      ld_inv & (ld_inv_index[1:0] == 2'd1) |
                      wrreq & (fill_index[1:0] == 2'd1);
   assign wrt_en[2] = word0_inv & inv_pkt & inv_index[0] |
                      ld_inv & (ld_inv_index[1:0] == 2'd2) |
                      wrreq & (fill_index[1:0] == 2'd2);
   assign wrt_en[3] = word1_inv & inv_pkt & inv_index[0] |
                      ld_inv & (ld_inv_index[1:0] == 2'd3) |
                      wrreq & (fill_index[1:0] == 2'd3);

   // stall repeats the last accepted enables
   assign wrt_en_bf = ifqadv ? wrt_en : wrt_en_q;

   // ---------------------------------------------------------
   // final write enables
   // ---------------------------------------------------------
   // odd groups are word 1, upper two groups are address 6 high
   always_comb begin
      for (int g = 0; g < 4; g++) begin
         icv_wren[`IC_WAYS*g +: `IC_WAYS] =
            ((g[0] ? w1_dec : w0_dec) & {`IC_WAYS{wrt_en_bf[g]}}) |
            {`IC_WAYS{invall & (pa5 == g[0]) & (inv_index[0] == g[1])}};
      end
   end

   // ---------------------------------------------------------
   // index selection
   // ---------------------------------------------------------
   // invalidates address a 64B line, so address 5 is zero
   assign icv_wrindex = (wrreq | !ifqadv) ? fill_index :
                        ld_inv            ? ld_inv_index :
                                            {inv_index, 1'b0};

   // ---------------------------------------------------------
   // invalidation request
   // ---------------------------------------------------------
   assign invalidate = inv_pkt & (word0_inv | word1_inv | iinv) | ld_inv;

   assign inv_pending = invalidate;
   assign invreq      = ifqadv ? invalidate : inv_q;

   // ---------------------------------------------------------
   // hold registers
   // ---------------------------------------------------------
   always_ff @(posedge rclk or negedge rst_n) begin
      if (!rst_n) begin
         w0_way_q <= '0;
         w1_way_q <= '0;
         wrt_en_q <= '0;
         inv_q    <= 1'b0;
      end else begin
         w0_way_q <= w0_way;
         w1_way_q <= w1_way;
         wrt_en_q <= wrt_en_bf;
         inv_q    <= invreq;
      end
   end

   // ---------------------------------------------------------
   // checks
   // ---------------------------------------------------------
   // stalled queue right out of reset writes nothing
   a_quiet_after_rst: assert property (
      @(posedge rclk) $rose(rst_n) && !ifqadv |-> icv_wren == '0 && !invreq)
      else $error("valid array write right after reset");

endmodule

//--- logic/ifu_inv_ctl.sv
// ----------------------------------------------------------
// icache valid array invalidation control, top level;
// connects packet decode, load index table and write control
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "inv_params.svh"

module ifu_inv_ctl (
   input  logic                      rclk,
   input  logic                      rst_n,
   input  logic [2:0]                const_cpuid,
   input  logic [`INV_PKT_WIDTH-1:0] ifqop,
   input  logic                      ifqadv,
   input  logic                      asireq,
   input  inv_pkg::ic_way_t          wrway,
   input  inv_pkg::ic_index_t        fill_index,
   input  logic                      ld_pkt_vld,
   input  logic [1:0]                ld_tid,
   input  inv_pkg::ic_index_t        ld_index,
   output inv_pkg::ic_index_t        icv_wrindex,
   output inv_pkg::icv_wren_t        icv_wren,
   output logic                      invreq,
   output logic                      inv_pending
);

   // decode results
   inv_pkg::cpx_op_e   op;
   logic               ld_inv;
   inv_pkg::ic_way_t   ld_way;
   logic               word0_inv;
   logic               word1_inv;
   inv_pkg::ic_way_t   wd0_way;
   inv_pkg::ic_way_t   wd1_way;
   logic [5:0]         inv_index;
   logic               iinv;
   logic               pa5;
   logic [1:0]         pkt_thr;
   // index of the load being returned
   inv_pkg::ic_index_t ld_inv_index;

   // ---------------------------------------------------------
   // packet decode
   // ---------------------------------------------------------
   inv_pkt_decode u_decode (
      .const_cpuid (const_cpuid),
      .ifqop       (ifqop),
      .op          (op),
      .ld_inv      (ld_inv),
      .ld_way      (ld_way),
      .word0_inv   (word0_inv),
      .word1_inv   (word1_inv),
      .wd0_way     (wd0_way),
      .wd1_way     (wd1_way),
      .inv_index   (inv_index),
      .iinv        (iinv),
      .pa5         (pa5),
      .pkt_thr     (pkt_thr)
   );

   // ---------------------------------------------------------
   // load index table
   // ---------------------------------------------------------
   ld_index_table u_ld_table (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .ld_pkt_vld   (ld_pkt_vld),
      .ld_tid       (ld_tid),
      .ld_index     (ld_index),
      .pkt_thr      (pkt_thr),
      .ld_inv_index (ld_inv_index)
   );

   // ---------------------------------------------------------
   // write control
   // ---------------------------------------------------------
   icv_write_ctl u_write (
      .rclk         (rclk),
      .rst_n        (rst_n),
      .ifqadv       (ifqadv),
      .asireq       (asireq),
      .wrway        (wrway),
      .fill_index   (fill_index),
      .op           (op),
      .ld_inv       (ld_inv),
      .ld_way       (ld_way),
      .word0_inv    (word0_inv),
      .word1_inv    (word1_inv),
      .wd0_way      (wd0_way),
      .wd1_way      (wd1_way),
      .inv_index    (inv_index),
      .iinv         (iinv),
      .pa5          (pa5),
      .ld_inv_index (ld_inv_index),
      .icv_wrindex  (icv_wrindex),
      .icv_wren     (icv_wren),
      .invreq       (invreq),
      .inv_pending  (inv_pending)
   );

endmodule

//--- sim/tb_ifu_inv_ctl.sv
// ----------------------------------------------------------
// testbench for the invalidation control top level; replays
// one vector per cycle from the input file and compares
// index, enables and request against the expected columns
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "inv_params.svh"

module tb_ifu_inv_ctl;

   localparam int    CLK_PERIOD = 40;
   localparam int    RST_CYCLES = 10;
   localparam int    NUM_FIELDS = 21;
   localparam string VEC_FILE   = "sim/inv_input.txt";

   logic                      rclk;
   logic                      rst_n;
   logic [2:0]                const_cpuid;
   logic [`INV_PKT_WIDTH-1:0] ifqop;
   logic                      ifqadv;
   logic                      asireq;
   inv_pkg::ic_way_t          wrway;
   inv_pkg::ic_index_t        fill_index;
   logic                      ld_pkt_vld;
   logic [1:0]                ld_tid;
   inv_pkg::ic_index_t        ld_index;
   inv_pkg::ic_index_t        icv_wrindex;
   inv_pkg::icv_wren_t        icv_wren;
   logic                      invreq;
   logic                      inv_pending;

   // columns of the current vector
   logic [31:0] fld [NUM_FIELDS];
   int          vec_total;
   bit          vec_counted;

   ifu_inv_ctl u_dut (
      .rclk        (rclk),
      .rst_n       (rst_n),
      .const_cpuid (const_cpuid),
      .ifqop       (ifqop),
      .ifqadv      (ifqadv),
      .asireq      (asireq),
      .wrway       (wrway),
      .fill_index  (fill_index),
      .ld_pkt_vld  (ld_pkt_vld),
      .ld_tid      (ld_tid),
      .ld_index    (ld_index),
      .icv_wrindex (icv_wrindex),
      .icv_wren    (icv_wren),
      .invreq      (invreq),
      .inv_pending (inv_pending)
   );

   // ---------------------------------------------------------
   // clock and watchdog
   // ---------------------------------------------------------
   initial begin
      rclk = 1'b0;
      forever #(CLK_PERIOD / 2) rclk = ~rclk;
   end

   // budget is reset plus every vector plus margin
   initial begin
      wait (vec_counted);
      #((vec_total + 20) * CLK_PERIOD);
      abort_run("test timed out before all vectors were applied");
   end

   // ---------------------------------------------------------
   // helpers
   // ---------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run aborted");
   endtask

   // skips comment and blank lines
   // status 1 on a vector, 0 at end of file, -1 on a bad line
   task automatic next_vector(input int fd, output int status);
      string line;
      int    got;
      int    n;
      status = 0;
      got    = 1;
      while (status == 0 && got != 0) begin
         got = $fgets(line, fd);
         if (got != 0 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                        fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                        fld[14], fld[15], fld[16], fld[17], fld[18], fld[19], fld[20]);
            if (n == NUM_FIELDS) begin
               status = 1;
            end else if (n > 0) begin
               status = -1;
            end
         end
      end
   endtask

   // packet is given field by field and packed here
   task automatic drive_vector();
      logic [`INV_PKT_WIDTH-1:0] pkt;
      pkt = '0;
      pkt[`INV_OP_HI:`INV_OP_LO]   = fld[1][3:0];
      pkt[`INV_THR_HI:`INV_THR_LO] = fld[2][1:0];
      pkt[`INV_IINV]               = fld[3][0];
      pkt[`INV_PA5]                = fld[4][0];
      pkt[`INV_WYVLD]              = fld[5][0];
      pkt[`INV_WAY_HI:`INV_WAY_LO] = fld[6][1:0];
      pkt[`INV_IDX_HI:`INV_IDX_LO] = fld[7][5:0];
      pkt[`INV_W1_LO +: 32]        = fld[8];
      pkt[`INV_W0_LO +: 32]        = fld[9];
      const_cpuid <= fld[0][2:0];
      ifqop       <= pkt;
      ifqadv      <= fld[10][0];
      asireq      <= fld[11][0];
      wrway       <= fld[12][1:0];
      fill_index  <= fld[13][6:0];
      ld_pkt_vld  <= fld[14][0];
      ld_tid      <= fld[15][1:0];
      ld_index    <= fld[16][6:0];
   endtask

   task automatic check_field(input string name, input logic [15:0] expected,
                              input logic [15:0] actual, input int vec_no);
      assert (actual === expected) else begin
         $display("ERROR: vector %0d %s expected 0x%h actual 0x%h",
                  vec_no, name, expected, actual);
         abort_run("output mismatch");
      end
   endtask

   // ---------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------
   initial begin
      int fd;
      int status;
      int vec_no;
      const_cpuid = '0;
      ifqop       = '0;
      ifqadv      = 1'b0;
      asireq      = 1'b0;
      wrway       = '0;
      fill_index  = '0;
      ld_pkt_vld  = 1'b0;
      ld_tid      = '0;
      ld_index    = '0;
      rst_n       = 1'b0;
      vec_total   = 0;
      vec_counted = 1'b0;

      // first pass sizes the watchdog
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) abort_run("cannot open the vector file");
      next_vector(fd, status);
      while (status == 1) begin
         vec_total++;
         next_vector(fd, status);
      end
      $fclose(fd);
      if (status < 0) abort_run("malformed line in the vector file");
      if (vec_total == 0) abort_run("vector file holds no vectors");
      vec_counted = 1'b1;

      repeat (RST_CYCLES) @(posedge rclk);
      rst_n <= 1'b1;

      // drive on the edge, check just before the next one
      fd     = $fopen(VEC_FILE, "r");
      vec_no = 0;
      next_vector(fd, status);
      while (status == 1) begin
         vec_no++;
         @(posedge rclk);
         drive_vector();
         #(CLK_PERIOD - 5);
         check_field("icv_wrindex", fld[17][15:0], 16'(icv_wrindex), vec_no);
         check_field("icv_wren", fld[18][15:0], 16'(icv_wren), vec_no);
         check_field("invreq", fld[19][15:0], 16'(invreq), vec_no);
         check_field("inv_pending", fld[20][15:0], 16'(inv_pending), vec_no);
         next_vector(fd, status);
      end
      $fclose(fd);

      if (vec_no == vec_total) begin
         $display("TEST PASSED");
      end else begin
         $display("vector count changed between passes");
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+include
logic/inv_pkg.sv
logic/inv_pkt_decode.sv
logic/ld_index_table.sv
logic/icv_write_ctl.sv
logic/ifu_inv_ctl.sv
sim/tb_ifu_inv_ctl.sv

//--- sim/inv_input.txt
# cpuid op thr iinv pa5 wyvld ldway idx w1 w0 adv asi wrway fidx ldvld tid ldidx
#   then expected: icv_wrindex icv_wren invreq inv_pending (all hex, one cycle per line)
5 0 0 0 0 0 0 00 00000000 00000000 0 0 0 00 0 0 00 00 0000 0 0
5 0 0 0 0 0 0 00 00000000 00000000 1 0 0 15 0 0 00 00 0000 0 0
5 c 0 0 0 0 0 13 00ae0000 000e0000 1 0 0 15 0 0 00 26 4000 1 1
5 c 0 0 0 0 0 13 00ae0000 000e0000 0 0 0 15 0 0 00 15 4000 1 1
5 c 0 0 0 0 0 13 00ae0000 000e0000 0 0 0 15 0 0 00 15 4000 1 1
5 0 0 0 0 0 0 00 00000000 00000000 1 0 0 15 0 0 00 00 0000 0 0
5 b 0 0 0 0 0 2a 00600000 00000000 1 0 0 15 0 0 00 54 0020 1 1
5 e 0 0 0 0 0 01 00200000 00e00000 1 0 0 15 0 0 00 02 1800 1 1
5 c 0 0 0 0 0 05 000e0000 000e0000 1 0 0 15 0 0 00 0a 0000 0 0
5 0 0 0 0 0 0 00 00000000 00000000 1 0 0 15 1 2 4e 00 0000 0 0
5 0 0 0 0 0 0 00 00000000 00000000 1 0 0 15 1 1 33 00 0000 0 0
5 8 2 0 0 1 3 3f 00000000 00000000 1 0 0 15 0 0 00 4e 0800 1 1
5 8 1 0 0 1 1 3f 00000000 00000000 1 0 0 15 0 0 00 33 2000 1 1
5 8 2 0 0 0 2 3f 00000000 00000000 1 0 0 15 0 0 00 7e 0000 0 0
5 9 0 0 0 0 0 00 00000000 00000000 1 0 2 2d 0 0 00 2d 0040 0 0
5 0 0 0 0 0 0 00 00000000 00000000 1 1 1 1e 0 0 00 1e 0200 0 0
5 0 0 0 0 0 0 00 00000000 00000000 0 0 0 1e 0 0 00 1e 0200 0 0
5 0 0 0 0 0 0 00 00000000 00000000 1 0 0 1e 0 0 00 00 0000 0 0
5 c 0 1 1 0 0 08 00000000 00000000 1 0 0 1e 0 0 00 10 00f0 1 1
5 c 0 1 0 0 0 09 00600000 00000000 1 0 0 1e 0 0 00 12 2f00 1 1
5 c 0 1 0 0 0 09 00600000 00000000 0 0 0 1e 0 0 00 1e 2000 1 1
5 e 0 1 1 0 0 00 00000000 00000000 1 0 0 1e 0 0 00 00 0000 1 1
5 0 0 0 0 0 0 00 00000000 00000000 1 0 0 1e 0 0 00 00 0000 0 0
5 0 0 0 0 0 0 00 00000000 00000000 0 0 0 07 0 0 00 07 0000 0 0
